//--- Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/dcache_store.sv
  - design/dcache_rport.sv
  - design/dcache_refill.sv
  - design/dcache_top.sv
  - target: test
    files:
      - tests/dcache_mem_model.sv
      - tests/dcache_tb.sv

//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  typedef logic [31:0] addr_t;    // physical byte address
  typedef logic [31:0] word_t;
  typedef logic [2:0]  ld_type_t;

  // load type codes, bit 2 marks zero extension
  localparam ld_type_t LD_B  = 3'b000;
  localparam ld_type_t LD_H  = 3'b001;
  localparam ld_type_t LD_W  = 3'b010;
  localparam ld_type_t LD_BU = 3'b100;
  localparam ld_type_t LD_HU = 3'b101;

  localparam int UNCACHED_BIT = 31;    // set means bypass the cache

  // shift the addressed field down and extend it to a full word
  function automatic word_t load_fmt(input word_t word, input logic [1:0] off,
                                     input ld_type_t ld_type);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[{off, 3'b000} +: 8];
    h = off[1] ? word[31:16] : word[15:0];    // halfword picked by bit 1
    case (ld_type)
      LD_B:    return {{24{b[7]}}, b};
      LD_BU:   return {24'h0, b};
      LD_H:    return {{16{h[15]}}, h};
      LD_HU:   return {16'h0, h};
      default: return word;    // LD_W
    endcase
  endfunction

endpackage

`default_nettype wire

//--- design/dcache_refill.sv
`default_nettype none

module dcache_refill
  import dcache_pkg::*;
#(
  parameter int WAY_CNT = 2,
  parameter int IDX_LEN = 6,
  localparam int TAG_LEN = 30 - IDX_LEN
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                fill_req_i,
  input  wire addr_t         fill_addr_i,
  input  wire                fill_uncached_i,
  input  wire                mem_ack_i,
  input  wire word_t         mem_rdata_i,
  output logic               fill_done_o,
  output word_t              fill_rdata_o,
  output logic               init_busy_o,
  output logic               mem_req_o,
  output addr_t              mem_addr_o,
  output logic [WAY_CNT-1:0] wr_way_en_o,
  output logic [IDX_LEN-1:0] wr_idx_o,
  output logic [TAG_LEN-1:0] wr_tag_o,
  output logic               wr_valid_o,
  output word_t              wr_data_o
);

  typedef logic [IDX_LEN-1:0] idx_t;
  typedef enum logic [2:0] {INIT, IDLE, REQ, DROP, DONE} state_e;

  state_e             state_q, state_d;
  idx_t               sweep_q;     // index being invalidated
  logic [WAY_CNT-1:0] victim_q;    // one-hot round-robin pointer
  logic [WAY_CNT-1:0] victim_next;
  addr_t              addr_q;
  logic               uncached_q;
  word_t              data_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      INIT: if (&sweep_q) state_d = IDLE;
      IDLE: if (fill_req_i) state_d = REQ;
      REQ:  if (mem_ack_i) state_d = DROP;     // data captured here
      DROP: if (!mem_ack_i) state_d = DONE;    // wait for ack low
      DONE: state_d = IDLE;
      default: state_d = INIT;
    endcase
  end

  // rotate left, wraps to way 0
  assign victim_next = (victim_q << 1) | (victim_q >> (WAY_CNT - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= INIT;
      sweep_q  <= '0;
      victim_q <= WAY_CNT'(1);
    end else begin
      state_q <= state_d;
      if (state_q == INIT) begin
        sweep_q <= sweep_q + 1'b1;
      end
      if (state_q == DONE && !uncached_q) begin
        victim_q <= victim_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && fill_req_i) begin
      addr_q     <= {fill_addr_i[31:2], 2'b00};    // word aligned request
      uncached_q <= fill_uncached_i;
    end
    if (state_q == REQ && mem_ack_i) begin
      data_q <= mem_rdata_i;
    end
  end

  assign mem_req_o    = (state_q == REQ);
  assign mem_addr_o   = addr_q;
  assign fill_done_o  = (state_q == DONE);
  assign fill_rdata_o = data_q;
  assign init_busy_o  = (state_q == INIT);

  // store write, whole row during the sweep, victim way on a cacheable fill
  always_comb begin
    wr_way_en_o = '0;
    if (state_q == INIT) begin
      wr_way_en_o = '1;
    end else if (state_q == DONE && !uncached_q) begin
      wr_way_en_o = victim_q;
    end
  end

  assign wr_idx_o   = (state_q == INIT) ? sweep_q : addr_q[IDX_LEN+1:2];
  assign wr_tag_o   = addr_q[31:IDX_LEN+2];
  assign wr_valid_o = (state_q == DONE);    // low while sweeping
  assign wr_data_o  = data_q;

endmodule

`default_nettype wire

//--- design/dcache_rport.sv
`default_nettype none

module dcache_rport
  import dcache_pkg::*;
#(
  parameter int WAY_CNT = 2,
  parameter int IDX_LEN = 6,
  localparam int TAG_LEN = 30 - IDX_LEN
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            ld_valid_i,
  input  wire addr_t                     ld_addr_i,
  input  wire ld_type_t                  ld_type_i,
  input  wire                            init_busy_i,
  input  wire [WAY_CNT-1:0][TAG_LEN-1:0] rd_tags_i,
  input  wire [WAY_CNT-1:0]              rd_valids_i,
  input  wire word_t [WAY_CNT-1:0]       rd_datas_i,
  input  wire                            fill_done_i,
  input  wire word_t                     fill_rdata_i,
  input  wire [WAY_CNT-1:0]              wr_way_en_i,
  input  wire [IDX_LEN-1:0]              wr_idx_i,
  input  wire [TAG_LEN-1:0]              wr_tag_i,
  input  wire                            wr_valid_i,
  input  wire word_t                     wr_data_i,
  output logic                           busy_o,
  output word_t                          rdata_o,
  output logic                           rvalid_o,
  output logic [IDX_LEN-1:0]             rd_idx_o,
  output logic                           fill_req_o,
  output addr_t                          fill_addr_o,
  output logic                           fill_uncached_o
);

  typedef logic [TAG_LEN-1:0] tag_t;
  typedef logic [IDX_LEN-1:0] idx_t;
  typedef enum logic [1:0] {NORMAL, FILL, RESP} state_e;

  state_e state_q, state_d;
  logic   stall;    // freezes EX, M1 and M2

  // EX
  logic     ex_valid_q;
  addr_t    ex_addr_q;
  ld_type_t ex_type_q;

  // M1
  logic               m1_valid_q;
  addr_t              m1_addr_q;
  ld_type_t           m1_type_q;
  logic               m1_hold_q;    // stall copy replaces store output
  tag_t  [WAY_CNT-1:0] hold_tags_q;
  logic  [WAY_CNT-1:0] hold_valids_q;
  word_t [WAY_CNT-1:0] hold_datas_q;
  tag_t  [WAY_CNT-1:0] m1_tags;
  logic  [WAY_CNT-1:0] m1_valids;
  word_t [WAY_CNT-1:0] m1_datas;
  logic  [WAY_CNT-1:0] m1_hit;
  idx_t               m1_idx;
  tag_t               m1_tag;

  // store write seen one cycle ago
  logic [WAY_CNT-1:0] wb_way_en_q;
  idx_t               wb_idx_q;
  tag_t               wb_tag_q;
  logic               wb_valid_q;
  word_t              wb_data_q;

  // M2
  logic                m2_valid_q;
  addr_t               m2_addr_q;
  ld_type_t            m2_type_q;
  logic  [WAY_CNT-1:0] m2_hit_q;
  word_t [WAY_CNT-1:0] m2_datas_q;
  logic                m2_hit;
  logic                m2_miss;
  word_t               hit_word;
  word_t               fill_word_q;

  assign rd_idx_o = ex_addr_q[IDX_LEN+1:2];    // EX drives the store read

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid_q <= 1'b0;
      m1_valid_q <= 1'b0;
      m2_valid_q <= 1'b0;
    end else if (!stall) begin
      ex_valid_q <= ld_valid_i;    // accepted only while not busy
      m1_valid_q <= ex_valid_q;
      m2_valid_q <= m1_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_addr_q  <= ld_addr_i;
      ex_type_q  <= ld_type_i;
      m1_addr_q  <= ex_addr_q;
      m1_type_q  <= ex_type_q;
      m2_addr_q  <= m1_addr_q;
      m2_type_q  <= m1_type_q;
      m2_hit_q   <= m1_hit;
      m2_datas_q <= m1_datas;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m1_hold_q   <= 1'b0;
      wb_way_en_q <= '0;
    end else begin
      m1_hold_q   <= stall;
      wb_way_en_q <= wr_way_en_i;
    end
  end

  always_ff @(posedge clk) begin
    wb_idx_q      <= wr_idx_i;
    wb_tag_q      <= wr_tag_i;
    wb_valid_q    <= wr_valid_i;
    wb_data_q     <= wr_data_i;
    hold_tags_q   <= m1_tags;    // recirculates while held
    hold_valids_q <= m1_valids;
    hold_datas_q  <= m1_datas;
  end

  assign m1_idx = m1_addr_q[IDX_LEN+1:2];
  assign m1_tag = m1_addr_q[31:IDX_LEN+2];

  // forwarding, the current write wins over the older one
  always_comb begin
    m1_tags   = m1_hold_q ? hold_tags_q : rd_tags_i;
    m1_valids = m1_hold_q ? hold_valids_q : rd_valids_i;
    m1_datas  = m1_hold_q ? hold_datas_q : rd_datas_i;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (wb_way_en_q[w] && wb_idx_q == m1_idx) begin
        m1_tags[w]   = wb_tag_q;
        m1_valids[w] = wb_valid_q;
        m1_datas[w]  = wb_data_q;
      end
      if (wr_way_en_i[w] && wr_idx_i == m1_idx) begin
        m1_tags[w]   = wr_tag_i;
        m1_valids[w] = wr_valid_i;
        m1_datas[w]  = wr_data_i;
      end
      m1_hit[w] = m1_valids[w] && (m1_tags[w] == m1_tag) && !m1_addr_q[UNCACHED_BIT];
    end
  end

  always_comb begin
    hit_word = '0;
    for (int w = 0; w < WAY_CNT; w++) begin
      if (m2_hit_q[w]) begin
        hit_word = hit_word | m2_datas_q[w];
      end
    end
  end

  assign m2_hit  = |m2_hit_q;
  assign m2_miss = m2_valid_q && !m2_hit;    // uncached loads land here too

  always_comb begin
    state_d = state_q;
    case (state_q)
      NORMAL:  if (m2_miss) state_d = FILL;
      FILL:    if (fill_done_i) state_d = RESP;
      RESP:    state_d = NORMAL;
      default: state_d = NORMAL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= NORMAL;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FILL && fill_done_i) begin
      fill_word_q <= fill_rdata_i;
    end
  end

  // pipeline released in RESP so the next load moves up with the answer
  assign stall  = init_busy_i || (state_q == FILL) || (state_q == NORMAL && m2_miss);
  assign busy_o = stall;

  assign rvalid_o = (state_q == NORMAL && m2_valid_q && m2_hit) || (state_q == RESP);
  assign rdata_o  = load_fmt((state_q == RESP) ? fill_word_q : hit_word,
                             m2_addr_q[1:0], m2_type_q);

  assign fill_req_o      = (state_q == FILL);
  assign fill_addr_o     = m2_addr_q;
  assign fill_uncached_o = m2_addr_q[UNCACHED_BIT];

endmodule

`default_nettype wire

//--- design/dcache_store.sv
`default_nettype none

module dcache_store
  import dcache_pkg::*;
#(
  parameter int WAY_CNT = 2,
  parameter int IDX_LEN = 6,
  localparam int TAG_LEN = 30 - IDX_LEN
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [IDX_LEN-1:0]              rd_idx_i,
  input  wire [WAY_CNT-1:0]              wr_way_en_i,
  input  wire [IDX_LEN-1:0]              wr_idx_i,
  input  wire [TAG_LEN-1:0]              wr_tag_i,
  input  wire                            wr_valid_i,
  input  wire word_t                     wr_data_i,
  output logic [WAY_CNT-1:0][TAG_LEN-1:0] rd_tags_o,
  output logic [WAY_CNT-1:0]             rd_valids_o,
  output word_t [WAY_CNT-1:0]            rd_datas_o
);

  localparam int LINE_CNT = 2 ** IDX_LEN;

  typedef logic [TAG_LEN-1:0] tag_t;

  for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
    tag_t               tag_mem  [LINE_CNT];
    word_t              data_mem [LINE_CNT];
    logic [LINE_CNT-1:0] valid_mem;    // cleared by the refill sweep

    // one write port, tag valid and word go together
    always_ff @(posedge clk) begin
      if (wr_way_en_i[w]) begin
        tag_mem[wr_idx_i]   <= wr_tag_i;
        valid_mem[wr_idx_i] <= wr_valid_i;
        data_mem[wr_idx_i]  <= wr_data_i;
      end
    end

    // registered read, old contents on a same-index write
    always_ff @(posedge clk) begin
      rd_tags_o[w]  <= tag_mem[rd_idx_i];
      rd_datas_o[w] <= data_mem[rd_idx_i];
    end

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        rd_valids_o[w] <= 1'b0;
      end else begin
        rd_valids_o[w] <= valid_mem[rd_idx_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`default_nettype none

module dcache_top
  import dcache_pkg::*;
#(
  parameter int WAY_CNT = 2,
  parameter int IDX_LEN = 6
) (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           ld_valid_i,
  input  wire addr_t    ld_addr_i,
  input  wire ld_type_t ld_type_i,
  input  wire           mem_ack_i,
  input  wire word_t    mem_rdata_i,
  output logic          busy_o,
  output word_t         rdata_o,
  output logic          rvalid_o,
  output logic          mem_req_o,
  output addr_t         mem_addr_o
);

  localparam int TAG_LEN = 30 - IDX_LEN;

  // store read side
  logic [IDX_LEN-1:0]              rd_idx;
  logic [WAY_CNT-1:0][TAG_LEN-1:0] rd_tags;
  logic [WAY_CNT-1:0]              rd_valids;
  word_t [WAY_CNT-1:0]             rd_datas;

  // read port to refill engine
  logic  fill_req;
  addr_t fill_addr;
  logic  fill_uncached;
  logic  fill_done;
  word_t fill_rdata;
  logic  init_busy;

  // store write side, also snooped by the read port
  logic [WAY_CNT-1:0] wr_way_en;
  logic [IDX_LEN-1:0] wr_idx;
  logic [TAG_LEN-1:0] wr_tag;
  logic               wr_valid;
  word_t              wr_data;

  dcache_rport #(
    .WAY_CNT(WAY_CNT),
    .IDX_LEN(IDX_LEN)
  ) u_rport (
    .clk(clk), .rst_n(rst_n),
    .ld_valid_i(ld_valid_i), .ld_addr_i(ld_addr_i), .ld_type_i(ld_type_i),
    .init_busy_i(init_busy),
    .rd_tags_i(rd_tags), .rd_valids_i(rd_valids), .rd_datas_i(rd_datas),
    .fill_done_i(fill_done), .fill_rdata_i(fill_rdata),
    .wr_way_en_i(wr_way_en), .wr_idx_i(wr_idx), .wr_tag_i(wr_tag),
    .wr_valid_i(wr_valid), .wr_data_i(wr_data),
    .busy_o(busy_o), .rdata_o(rdata_o), .rvalid_o(rvalid_o), .rd_idx_o(rd_idx),
    .fill_req_o(fill_req), .fill_addr_o(fill_addr), .fill_uncached_o(fill_uncached)
  );

  dcache_store #(
    .WAY_CNT(WAY_CNT),
    .IDX_LEN(IDX_LEN)
  ) u_store (
    .clk(clk), .rst_n(rst_n), .rd_idx_i(rd_idx),
    .wr_way_en_i(wr_way_en), .wr_idx_i(wr_idx), .wr_tag_i(wr_tag),
    .wr_valid_i(wr_valid), .wr_data_i(wr_data),
    .rd_tags_o(rd_tags), .rd_valids_o(rd_valids), .rd_datas_o(rd_datas)
  );

  dcache_refill #(
    .WAY_CNT(WAY_CNT),
    .IDX_LEN(IDX_LEN)
  ) u_refill (
    .clk(clk), .rst_n(rst_n),
    .fill_req_i(fill_req), .fill_addr_i(fill_addr), .fill_uncached_i(fill_uncached),
    .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
    .fill_done_o(fill_done), .fill_rdata_o(fill_rdata), .init_busy_o(init_busy),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o),
    .wr_way_en_o(wr_way_en), .wr_idx_o(wr_idx), .wr_tag_o(wr_tag),
    .wr_valid_o(wr_valid), .wr_data_o(wr_data)
  );

endmodule

`default_nettype wire

//--- files.f
design/dcache_pkg.sv
design/dcache_store.sv
design/dcache_rport.sv
design/dcache_refill.sv
design/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

//--- tests/dcache_mem_model.sv
`default_nettype none

module dcache_mem_model
  import dcache_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        mem_req_i,
  input  wire addr_t mem_addr_i,
  output logic       mem_ack_o = 1'b0,
  output word_t      mem_rdata_o = '0,
  output int         req_cnt_o = 0,    // completed handshakes
  output logic       proto_err_o = 1'b0
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {WAIT_REQ, DELAY, ACKED} mstate_e;

  mstate_e     state = WAIT_REQ;
  logic [31:0] rng = 32'd55977;
  logic [1:0]  delay;
  addr_t       addr_q;
  logic        req_q = 1'b0;    // req seen at the previous falling edge

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory contents follow the address
  function automatic word_t mem_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  task automatic flag(input string why);
    $display("memory model at %0t ns: %s", $time, why);
    proto_err_o = 1'b1;
  endtask

  // ack side is driven on the falling edge like every other DUT input
  always @(negedge clk) begin
    if (!rst_n) begin
      state     = WAIT_REQ;
      mem_ack_o = 1'b0;
      req_q     = 1'b0;
    end else begin
      if (mem_req_i && !req_q && mem_ack_o) begin
        flag("request raised while acknowledge still high");
      end
      case (state)
        WAIT_REQ: if (mem_req_i) begin
          addr_q = mem_addr_i;
          rng    = xorshift(rng);
          delay  = rng[1:0];    // 0 to 3 cycles
          state  = DELAY;
        end
        DELAY: begin
          if (!mem_req_i) begin
            flag("request dropped before acknowledge");
          end else if (mem_addr_i !== addr_q) begin
            flag("address changed while request high");
          end else if (delay != 0) begin
            delay = delay - 1'b1;
          end
        end
        ACKED: begin
          if (!mem_req_i) begin
            mem_ack_o = 1'b0;
            req_cnt_o = req_cnt_o + 1;
            state     = WAIT_REQ;
          end else if (mem_addr_i !== addr_q) begin
            flag("address changed while request high");
          end
        end
        default: state = WAIT_REQ;
      endcase
      if (state == DELAY && delay == 0 && mem_req_i) begin
        mem_rdata_o = mem_word(addr_q);
        mem_ack_o   = 1'b1;
        state       = ACKED;
      end
      req_q = mem_req_i;
    end
  end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`default_nettype none

module dcache_tb
  import dcache_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAY_CNT     = 2;
  localparam int IDX_LEN     = 6;
  localparam int SWEEP_LIMIT = 2 ** IDX_LEN + 20;
  localparam int RESP_LIMIT  = 60;
  localparam int HIT_LAT     = 3;    // falling edges from drive to rvalid sample

  typedef struct packed {
    addr_t    addr;
    ld_type_t ld_type;
    logic [1:0] req_inc;    // memory requests this load should cause
    logic     b2b;          // issued the cycle after the previous row
  } row_t;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     ld_valid;
  addr_t    ld_addr;
  ld_type_t ld_type;
  logic     busy;
  word_t    rdata;
  logic     rvalid;
  logic     mem_req;
  addr_t    mem_addr;
  logic     mem_ack;
  word_t    mem_rdata;
  int       req_cnt;
  logic     proto_err;
  row_t     rows[$];

  always #10 clk = ~clk;

  dcache_top #(
    .WAY_CNT(WAY_CNT),
    .IDX_LEN(IDX_LEN)
  ) dut (
    .clk(clk), .rst_n(rst_n),
    .ld_valid_i(ld_valid), .ld_addr_i(ld_addr), .ld_type_i(ld_type),
    .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
    .busy_o(busy), .rdata_o(rdata), .rvalid_o(rvalid),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr)
  );

  dcache_mem_model u_mem (
    .clk(clk), .rst_n(rst_n), .mem_req_i(mem_req), .mem_addr_i(mem_addr),
    .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata), .req_cnt_o(req_cnt),
    .proto_err_o(proto_err)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run("stopping at the first mismatch");
    end
  endtask

  always @(posedge clk) begin
    if (proto_err) abort_run("memory handshake protocol violated");
  end

  function automatic word_t mem_word(input addr_t a);
    return {a[31:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  // expected load result with the field shifted down and extended
  function automatic word_t expect_load(input word_t w, input logic [1:0] off,
                                        input ld_type_t t);
    word_t sh;
    sh = w >> (off * 8);
    case (t)
      LD_B:    return {{24{sh[7]}}, sh[7:0]};
      LD_BU:   return sh & 32'h0000_00FF;
      LD_H:    return {{16{sh[15]}}, sh[15:0]};
      LD_HU:   return sh & 32'h0000_FFFF;
      default: return w;
    endcase
  endfunction

  task automatic add_row(input addr_t a, input ld_type_t t, input int inc, input bit b2b);
    row_t r;
    r.addr    = a;
    r.ld_type = t;
    r.req_inc = inc[1:0];
    r.b2b     = b2b;
    rows.push_back(r);
  endtask

  task automatic load_table();
    add_row(32'h0000_0100, LD_W, 1, 0);    // cold miss
    add_row(32'h0000_0100, LD_W, 0, 0);    // hit with latency check
    add_row(32'h0000_0100, LD_W, 0, 0);
    add_row(32'h0000_0102, LD_HU, 0, 1);
    add_row(32'h00A5_8084, LD_W, 1, 0);    // word 5AFF8084
    for (int o = 0; o < 4; o++) begin
      add_row(32'h00A5_8084 + o, LD_B, 0, 0);
      add_row(32'h00A5_8084 + o, LD_BU, 0, 0);
    end
    for (int o = 0; o < 4; o += 2) begin
      add_row(32'h00A5_8084 + o, LD_H, 0, 0);
      add_row(32'h00A5_8084 + o, LD_HU, 0, 0);
    end
    add_row(32'h8000_0012, LD_H, 1, 0);    // uncached with a negative upper half
    add_row(32'h8000_0012, LD_H, 1, 0);
    add_row(32'h8000_0013, LD_B, 1, 0);
    add_row(32'h8000_0010, LD_W, 1, 0);
    add_row(32'h0000_1014, LD_W, 1, 0);    // same index under three tags
    add_row(32'h0000_2014, LD_W, 1, 0);
    add_row(32'h0000_3014, LD_W, 1, 0);
    add_row(32'h0000_2014, LD_W, 0, 0);
    add_row(32'h0000_1014, LD_W, 1, 0);    // was evicted
    add_row(32'h0000_3014, LD_W, 0, 0);
    add_row(32'h0000_1016, LD_H, 0, 1);
  endtask

  task automatic wait_idle(input int limit, input string why);
    int n;
    n = 0;
    while (busy !== 1'b0) begin
      if (n >= limit) begin
        abort_run(why);
      end else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_rvalid(inout int lat);
    while (rvalid !== 1'b1) begin
      if (lat >= RESP_LIMIT) begin
        abort_run("no rvalid_o for an accepted load");
      end else begin
        @(negedge clk);
        lat++;
      end
    end
  endtask

  task automatic drive_load(input row_t row);
    ld_valid = 1'b1;
    ld_addr  = row.addr;
    ld_type  = row.ld_type;
  endtask

  initial begin
    int   r;
    int   lat;
    int   cnt0;
    int   inc;
    bit   pair;
    row_t cur;
    row_t nxt;
    rst_n    = 1'b0;
    ld_valid = 1'b0;
    ld_addr  = '0;
    ld_type  = LD_W;
    load_table();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_value("rvalid_o", rvalid, 1'b0);
    check_value("mem_req_o", mem_req, 1'b0);
    check_value("busy_o", busy, 1'b1);    // sweep still running
    wait_idle(SWEEP_LIMIT, "busy_o still high after the reset sweep");
    r = 0;
    while (r < rows.size()) begin
      cur  = rows[r];
      pair = (r + 1 < rows.size()) && rows[r + 1].b2b;
      nxt  = pair ? rows[r + 1] : cur;
      wait_idle(RESP_LIMIT, "busy_o never dropped before the next load");
      cnt0 = req_cnt;
      drive_load(cur);
      @(negedge clk);
      lat = 1;
      if (pair) begin
        check_value("busy_o", busy, 1'b0);
        drive_load(nxt);
        @(negedge clk);
        lat = 2;
      end
      ld_valid = 1'b0;
      wait_rvalid(lat);
      check_value("rdata_o", rdata,
                  expect_load(mem_word(cur.addr), cur.addr[1:0], cur.ld_type));
      if (cur.req_inc == 0) check_value("hit latency", lat, HIT_LAT);
      inc = cur.req_inc;
      if (pair) begin
        @(negedge clk);    // second answer in the very next cycle
        check_value("rvalid_o", rvalid, 1'b1);
        check_value("rdata_o", rdata,
                    expect_load(mem_word(nxt.addr), nxt.addr[1:0], nxt.ld_type));
        inc = inc + nxt.req_inc;
      end
      @(negedge clk);
      check_value("rvalid_o", rvalid, 1'b0);
      check_value("memory requests", req_cnt - cnt0, inc);
      r = r + (pair ? 2 : 1);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
